//--- rob_core.f
+incdir+hw
hw/instr_pkg.sv
hw/rob_pkg.sv
hw/wb_bus_if.sv
hw/rob_entry.sv
hw/exec_alu.sv
hw/exec_branch.sv
hw/wb_arbiter.sv
hw/rob_queue.sv
hw/rob_core.sv
tb/tb_rob_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the reorder buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_rob_core \
   -f rob_core.f -o sim_rob_core > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/sim_rob_core > sim.log 2>&1
cat sim.log

grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0

//--- tb/tb_rob_core.sv
`timescale 1ns/1ps
`include "rob_config.svh"

module tb_rob_core;

   localparam int TIMEOUT_NS = 6 * 200 * 8;
   localparam int WAIT_LIMIT = 200;

   logic                   clk = 1'b0;
   logic                   reset;
   logic                   alloc_valid;
   logic                   alloc_ready;
   instr_pkg::t_instr_kind alloc_kind;
   logic [`REG_W-1:0]      alloc_dest;
   rob_pkg::t_rob_id       alloc_id;
   logic                   alu_issue_valid;
   logic                   alu_issue_ready;
   rob_pkg::t_rob_id       alu_issue_robid;
   instr_pkg::t_alu_op     alu_issue_op;
   logic [`XLEN-1:0]       alu_src_a;
   logic [`XLEN-1:0]       alu_src_b;
   logic                   br_issue_valid;
   logic                   br_issue_ready;
   rob_pkg::t_rob_id       br_issue_robid;
   instr_pkg::t_br_cond    br_issue_cond;
   logic [`XLEN-1:0]       br_src_a;
   logic [`XLEN-1:0]       br_src_b;
   logic                   br_pred_taken;
   logic [`XLEN-1:0]       br_taken_target;
   logic [`XLEN-1:0]       br_fall_target;
   logic                   retire_valid;
   instr_pkg::t_instr_kind retire_kind;
   logic [`REG_W-1:0]      retire_dest;
   logic [`XLEN-1:0]       retire_value;
   logic                   flush_valid;
   logic [`XLEN-1:0]       flush_target;

   // Program order model with one slot per allocation
   instr_pkg::t_instr_kind m_kind [256];
   logic [`REG_W-1:0]      m_dest [256];
   logic [`XLEN-1:0]       m_value [256];
   logic                   m_mispred [256];
   int                     rd_ptr;
   int                     wr_ptr;

   int          errors = 0;
   int          err_at_start = 0;
   int          retired = 0;
   int          flushed = 0;
   int          tests_run = 0;
   logic [31:0] rand_state;
   string       test_name = "reset";

   instr_pkg::t_instr_kind exp_kind;
   logic [`REG_W-1:0]      exp_dest;
   logic [`XLEN-1:0]       exp_value;
   logic                   exp_mispred;
   logic                   exp_ready;

   assign exp_kind    = m_kind[rd_ptr];
   assign exp_dest    = m_dest[rd_ptr];
   assign exp_value   = m_value[rd_ptr];
   assign exp_mispred = m_mispred[rd_ptr];
   assign exp_ready   = (wr_ptr - rd_ptr) != `ROB_DEPTH;

   rob_core uut (.*);

   always #4 clk = ~clk;

   // Front of the model leaves on retire and everything leaves on flush
   always @(posedge clk) begin
      if (reset) begin
         rd_ptr <= 0;
         wr_ptr <= 0;
      end else begin
         if (alloc_valid && alloc_ready) wr_ptr <= wr_ptr + 1;
         if (flush_valid) begin
            rd_ptr  <= wr_ptr;
            flushed <= flushed + 1;
         end else if (retire_valid) begin
            rd_ptr  <= rd_ptr + 1;
            retired <= retired + 1;
         end
      end
   end

   a_retire_known: assert property (@(posedge clk) disable iff (reset)
      retire_valid |-> rd_ptr != wr_ptr)
      else begin
         errors++;
         $display("Error in %s: retire with no instruction outstanding", test_name);
      end

   a_retire_kind: assert property (@(posedge clk) disable iff (reset)
      retire_valid |-> retire_kind == exp_kind)
      else begin
         errors++;
         $display("Fail %s: retire_kind expected %0d actual %0d", test_name,
            $sampled(exp_kind), $sampled(retire_kind));
      end

   a_retire_dest: assert property (@(posedge clk) disable iff (reset)
      retire_valid |-> retire_dest == exp_dest)
      else begin
         errors++;
         $display("Fail %s: retire_dest expected %0d actual %0d", test_name,
            $sampled(exp_dest), $sampled(retire_dest));
      end

   a_retire_value: assert property (@(posedge clk) disable iff (reset)
      retire_valid |-> retire_value == exp_value)
      else begin
         errors++;
         $display("Fail %s: retire_value expected %h actual %h", test_name,
            $sampled(exp_value), $sampled(retire_value));
      end

   // A mispredicted branch must flush and never retire
   a_retire_no_flush: assert property (@(posedge clk) disable iff (reset)
      retire_valid |-> !exp_mispred)
      else begin
         errors++;
         $display("Error in %s: mispredicted branch retired instead of flushing", test_name);
      end

   a_flush_known: assert property (@(posedge clk) disable iff (reset)
      flush_valid |-> exp_mispred && rd_ptr != wr_ptr)
      else begin
         errors++;
         $display("Error in %s: flush from an instruction that predicted right", test_name);
      end

   a_flush_target: assert property (@(posedge clk) disable iff (reset)
      flush_valid |-> flush_target == exp_value)
      else begin
         errors++;
         $display("Fail %s: flush_target expected %h actual %h", test_name,
            $sampled(exp_value), $sampled(flush_target));
      end

   // Free room as counted by the model
   a_alloc_ready: assert property (@(posedge clk) disable iff (reset)
      !flush_valid |-> alloc_ready == exp_ready)
      else begin
         errors++;
         $display("Fail %s: alloc_ready expected %b actual %b", test_name,
            $sampled(exp_ready), $sampled(alloc_ready));
      end

   a_alloc_flush: assert property (@(posedge clk) disable iff (reset)
      flush_valid |-> !alloc_ready)
      else begin
         errors++;
         $display("Error in %s: allocation still open during a flush", test_name);
      end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] rand_word();
      rand_state = xorshift(rand_state);
      return rand_state;
   endfunction

   function automatic logic [`XLEN-1:0] alu_expect(input instr_pkg::t_alu_op op,
                                                   input logic [`XLEN-1:0] a,
                                                   input logic [`XLEN-1:0] b);
      case (op)
         instr_pkg::ADD: return a + b;
         instr_pkg::SUB: return a - b;
         instr_pkg::AND: return a & b;
         default:        return a ^ b;
      endcase
   endfunction

   function automatic logic branch_taken(input instr_pkg::t_br_cond cond,
                                         input logic [`XLEN-1:0] a,
                                         input logic [`XLEN-1:0] b);
      case (cond)
         instr_pkg::EQ:  return a == b;
         instr_pkg::NE:  return a != b;
         instr_pkg::LTU: return a < b;
         default:        return 1'b0;
      endcase
   endfunction

   // Called on a falling edge and returns on one
   task automatic alloc_instr(input instr_pkg::t_instr_kind kind, output int idx,
                              output rob_pkg::t_rob_id id);
      int          waited;
      logic [31:0] r;
      waited = 0;
      r = rand_word();
      alloc_valid = 1'b1;
      alloc_kind  = kind;
      alloc_dest  = r[`REG_W-1:0];
      while (!alloc_ready && waited < WAIT_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (!alloc_ready) begin
         errors++;
         $display("Error in %s: allocation was never accepted", test_name);
      end
      idx = wr_ptr;
      id  = alloc_id;
      m_kind[idx]    = kind;
      m_dest[idx]    = r[`REG_W-1:0];
      m_value[idx]   = '0;
      m_mispred[idx] = 1'b0;
      @(negedge clk);
      alloc_valid = 1'b0;
   endtask

   task automatic issue_alu(input int idx, input rob_pkg::t_rob_id id,
                            input instr_pkg::t_alu_op op,
                            input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
      int waited;
      waited = 0;
      m_value[idx]    = alu_expect(op, a, b);
      alu_issue_valid = 1'b1;
      alu_issue_robid = id;
      alu_issue_op    = op;
      alu_src_a       = a;
      alu_src_b       = b;
      while (!alu_issue_ready && waited < WAIT_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (!alu_issue_ready) begin
         errors++;
         $display("Error in %s: ALU never accepted the issue", test_name);
      end
      @(negedge clk);
      alu_issue_valid = 1'b0;
   endtask

   task automatic issue_branch(input int idx, input rob_pkg::t_rob_id id,
                               input instr_pkg::t_br_cond cond,
                               input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b,
                               input logic pred, input logic [`XLEN-1:0] tgt_taken,
                               input logic [`XLEN-1:0] tgt_fall);
      int   waited;
      logic taken;
      waited = 0;
      taken  = branch_taken(cond, a, b);
      m_value[idx]    = taken ? tgt_taken : tgt_fall;
      m_mispred[idx]  = (taken != pred);
      br_issue_valid  = 1'b1;
      br_issue_robid  = id;
      br_issue_cond   = cond;
      br_src_a        = a;
      br_src_b        = b;
      br_pred_taken   = pred;
      br_taken_target = tgt_taken;
      br_fall_target  = tgt_fall;
      while (!br_issue_ready && waited < WAIT_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (!br_issue_ready) begin
         errors++;
         $display("Error in %s: branch unit never accepted the issue", test_name);
      end
      @(negedge clk);
      br_issue_valid = 1'b0;
   endtask

   // Waits until the model entry at idx has retired or flushed
   task automatic wait_ended(input int idx);
      int waited;
      waited = 0;
      while (rd_ptr <= idx && waited < WAIT_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (rd_ptr <= idx) begin
         errors++;
         $display("Error in %s: instruction %0d never retired or flushed", test_name, idx);
      end
   endtask

   task automatic start_test(input string name);
      test_name    = name;
      err_at_start = errors;
   endtask

   task automatic end_test();
      wait_ended(wr_ptr - 1);
      tests_run++;
      $display("Test %s done with %0d errors", test_name, errors - err_at_start);
   endtask

   task automatic alu_ops();
      int               idx [4];
      rob_pkg::t_rob_id id [4];
      logic [31:0]      a;
      logic [31:0]      b;
      start_test("alu_ops");
      for (int i = 0; i < 4; i++) alloc_instr(instr_pkg::KIND_ALU, idx[i], id[i]);
      for (int i = 0; i < 4; i++) begin
         a = rand_word();
         b = rand_word();
         issue_alu(idx[i], id[i], instr_pkg::t_alu_op'(i), a, b);
      end
      end_test();
   endtask

   task automatic reverse_results();
      int               idx [4];
      rob_pkg::t_rob_id id [4];
      logic [31:0]      a;
      logic [31:0]      b;
      start_test("reverse_results");
      for (int i = 0; i < 4; i++) alloc_instr(instr_pkg::KIND_ALU, idx[i], id[i]);
      for (int i = 3; i >= 0; i--) begin
         a = rand_word();
         b = rand_word();
         issue_alu(idx[i], id[i], instr_pkg::SUB, a, b);
      end
      end_test();
   endtask

   task automatic branch_predicted();
      int               idx;
      rob_pkg::t_rob_id id;
      logic [31:0]      a;
      logic [31:0]      b;
      start_test("branch_predicted");
      alloc_instr(instr_pkg::KIND_BRANCH, idx, id);
      a = rand_word();
      b = rand_word();
      issue_branch(idx, id, instr_pkg::LTU, a, b, branch_taken(instr_pkg::LTU, a, b),
         rand_word(), rand_word());
      end_test();
   endtask

   task automatic mispredict_flush();
      int               idx [5];
      rob_pkg::t_rob_id id [5];
      logic [31:0]      a;
      start_test("mispredict_flush");
      alloc_instr(instr_pkg::KIND_ALU, idx[0], id[0]);
      alloc_instr(instr_pkg::KIND_ALU, idx[1], id[1]);
      alloc_instr(instr_pkg::KIND_BRANCH, idx[2], id[2]);
      // Younger entries that are never issued
      alloc_instr(instr_pkg::KIND_ALU, idx[3], id[3]);
      alloc_instr(instr_pkg::KIND_ALU, idx[4], id[4]);
      a = rand_word();
      issue_alu(idx[0], id[0], instr_pkg::ADD, a, rand_word());
      issue_alu(idx[1], id[1], instr_pkg::XOR, rand_word(), a);
      // Equal operands take the branch that was predicted not taken
      issue_branch(idx[2], id[2], instr_pkg::EQ, a, a, 1'b0, rand_word(), rand_word());
      end_test();
   endtask

   task automatic dual_issue();
      int               idx [2];
      rob_pkg::t_rob_id id [2];
      logic [31:0]      v [6];
      start_test("dual_issue");
      alloc_instr(instr_pkg::KIND_ALU, idx[0], id[0]);
      alloc_instr(instr_pkg::KIND_BRANCH, idx[1], id[1]);
      for (int i = 0; i < 6; i++) v[i] = rand_word();
      fork
         issue_alu(idx[0], id[0], instr_pkg::AND, v[0], v[1]);
         issue_branch(idx[1], id[1], instr_pkg::NE, v[2], v[3],
            branch_taken(instr_pkg::NE, v[2], v[3]), v[4], v[5]);
      join
      end_test();
   endtask

   task automatic fill_buffer();
      int               idx [`ROB_DEPTH + 1];
      rob_pkg::t_rob_id id [`ROB_DEPTH + 1];
      start_test("fill_buffer");
      for (int i = 0; i < `ROB_DEPTH; i++) alloc_instr(instr_pkg::KIND_ALU, idx[i], id[i]);
      @(negedge clk);
      issue_alu(idx[0], id[0], instr_pkg::ADD, rand_word(), rand_word());
      wait_ended(idx[0]);
      alloc_instr(instr_pkg::KIND_ALU, idx[`ROB_DEPTH], id[`ROB_DEPTH]);
      for (int i = 1; i <= `ROB_DEPTH; i++) begin
         issue_alu(idx[i], id[i], instr_pkg::XOR, rand_word(), rand_word());
      end
      end_test();
   endtask

   initial begin
      #(TIMEOUT_NS);
      $display("Watchdog expired after %0d ns with tests still running", TIMEOUT_NS);
      $display("Verification failed");
      $finish;
   end

   initial begin
      rand_state      = 32'h4aa8_3776;
      reset           = 1'b1;
      alloc_valid     = 1'b0;
      alloc_kind      = instr_pkg::KIND_ALU;
      alloc_dest      = '0;
      alu_issue_valid = 1'b0;
      alu_issue_robid = '0;
      alu_issue_op    = instr_pkg::ADD;
      alu_src_a       = '0;
      alu_src_b       = '0;
      br_issue_valid  = 1'b0;
      br_issue_robid  = '0;
      br_issue_cond   = instr_pkg::EQ;
      br_src_a        = '0;
      br_src_b        = '0;
      br_pred_taken   = 1'b0;
      br_taken_target = '0;
      br_fall_target  = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      alu_ops();
      reverse_results();
      branch_predicted();
      mispredict_flush();
      dual_issue();
      fill_buffer();
      $display("Tests %0d, retired %0d, flushed %0d, errors %0d",
         tests_run, retired, flushed, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

//--- hw/rob_core.sv
`timescale 1ns/1ps
`include "rob_config.svh"

module rob_core (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   alloc_valid,
   output logic                   alloc_ready,
   input  instr_pkg::t_instr_kind alloc_kind,
   input  logic [`REG_W-1:0]      alloc_dest,
   output rob_pkg::t_rob_id       alloc_id,
   input  logic                   alu_issue_valid,
   output logic                   alu_issue_ready,
   input  rob_pkg::t_rob_id       alu_issue_robid,
   input  instr_pkg::t_alu_op     alu_issue_op,
   input  logic [`XLEN-1:0]       alu_src_a,
   input  logic [`XLEN-1:0]       alu_src_b,
   input  logic                   br_issue_valid,
   output logic                   br_issue_ready,
   input  rob_pkg::t_rob_id       br_issue_robid,
   input  instr_pkg::t_br_cond    br_issue_cond,
   input  logic [`XLEN-1:0]       br_src_a,
   input  logic [`XLEN-1:0]       br_src_b,
   input  logic                   br_pred_taken,
   input  logic [`XLEN-1:0]       br_taken_target,
   input  logic [`XLEN-1:0]       br_fall_target,
   output logic                   retire_valid,
   output instr_pkg::t_instr_kind retire_kind,
   output logic [`REG_W-1:0]      retire_dest,
   output logic [`XLEN-1:0]       retire_value,
   output logic                   flush_valid,
   output logic [`XLEN-1:0]       flush_target
);

   logic                   alu_req, alu_grant;
   logic                   br_req, br_grant, br_mispred;
   rob_pkg::t_rob_id       alu_robid, br_robid;
   instr_pkg::t_wb_payload alu_payload, br_payload;

   wb_bus_if wb_bus ();

   exec_alu u_alu (
      .clk(clk), .reset(reset),
      .issue_valid(alu_issue_valid), .issue_ready(alu_issue_ready),
      .issue_robid(alu_issue_robid), .issue_op(alu_issue_op),
      .src_a(alu_src_a), .src_b(alu_src_b),
      .req(alu_req), .grant(alu_grant),
      .res_robid(alu_robid), .res_payload(alu_payload)
   );

   exec_branch u_branch (
      .clk(clk), .reset(reset),
      .issue_valid(br_issue_valid), .issue_ready(br_issue_ready),
      .issue_robid(br_issue_robid), .issue_cond(br_issue_cond),
      .src_a(br_src_a), .src_b(br_src_b), .pred_taken(br_pred_taken),
      .taken_target(br_taken_target), .fall_target(br_fall_target),
      .req(br_req), .grant(br_grant), .res_robid(br_robid),
      .res_mispred(br_mispred), .res_payload(br_payload)
   );

   wb_arbiter u_arb (
      .clk(clk), .reset(reset),
      .alu_req(alu_req), .alu_grant(alu_grant),
      .alu_robid(alu_robid), .alu_payload(alu_payload),
      .br_req(br_req), .br_grant(br_grant), .br_robid(br_robid),
      .br_mispred(br_mispred), .br_payload(br_payload),
      .wb(wb_bus.source)
   );

   rob_queue u_queue (
      .clk(clk), .reset(reset),
      .alloc_valid(alloc_valid), .alloc_ready(alloc_ready),
      .alloc_kind(alloc_kind), .alloc_dest(alloc_dest), .alloc_id(alloc_id),
      .wb(wb_bus.sink),
      .retire_valid(retire_valid), .retire_kind(retire_kind),
      .retire_dest(retire_dest), .retire_value(retire_value),
      .flush_valid(flush_valid), .flush_target(flush_target)
   );

endmodule

//--- hw/rob_queue.sv
`timescale 1ns/1ps
`include "rob_config.svh"

module rob_queue (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   alloc_valid,
   output logic                   alloc_ready,
   input  instr_pkg::t_instr_kind alloc_kind,
   input  logic [`REG_W-1:0]      alloc_dest,
   output rob_pkg::t_rob_id       alloc_id,
   wb_bus_if.sink                 wb,
   output logic                   retire_valid,
   output instr_pkg::t_instr_kind retire_kind,
   output logic [`REG_W-1:0]      retire_dest,
   output logic [`XLEN-1:0]       retire_value,
   output logic                   flush_valid,
   output logic [`XLEN-1:0]       flush_target
);

   rob_pkg::t_rob_id         head;
   rob_pkg::t_rob_id         tail;
   logic [`ROB_ID_W:0]       count;
   logic                     alloc_fire;
   rob_pkg::t_rob_ent_static alloc_s;
   rob_pkg::t_rob_ent        entries [`ROB_DEPTH];
   rob_pkg::t_rob_ent        head_ent;

   function automatic rob_pkg::t_rob_id next_ptr(input rob_pkg::t_rob_id ptr);
      if (ptr == rob_pkg::t_rob_id'(`ROB_DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign alloc_s.kind = alloc_kind;
   assign alloc_s.dest = alloc_dest;
   assign alloc_ready  = (count != (`ROB_ID_W+1)'(`ROB_DEPTH)) && !flush_valid;
   assign alloc_fire   = alloc_valid && alloc_ready;
   assign alloc_id     = tail;

   for (genvar i = 0; i < `ROB_DEPTH; i++) begin : g_ent
      rob_entry u_entry (
         .clk       (clk),
         .reset     (reset),
         .robid     (rob_pkg::t_rob_id'(i)),
         .alloc_s   (alloc_s),
         .alloc     (alloc_fire && (tail == rob_pkg::t_rob_id'(i))),
         .wb        (wb),
         .flush_now (flush_valid),
         .retire    (retire_valid && (head == rob_pkg::t_rob_id'(i))),
         .entry     (entries[i])
      );
   end

   // Everything is decided at the head
   assign head_ent     = entries[head];
   assign retire_valid = (head_ent.state == rob_pkg::READY);
   assign flush_valid  = (head_ent.state == rob_pkg::FLUSH);
   assign retire_kind  = head_ent.s.kind;
   assign retire_dest  = head_ent.s.dest;
   assign retire_value = head_ent.payload.data;
   assign flush_target = head_ent.payload.target;

   always_ff @(posedge clk) begin
      if (reset || flush_valid) begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
      end else begin
         if (retire_valid) head <= next_ptr(head);
         if (alloc_fire) tail <= next_ptr(tail);
         case ({alloc_fire, retire_valid})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   a_count_max: assert property (@(posedge clk) disable iff (reset)
      count <= (`ROB_ID_W+1)'(`ROB_DEPTH));

endmodule

//--- hw/wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   alu_req,
   output logic                   alu_grant,
   input  rob_pkg::t_rob_id       alu_robid,
   input  instr_pkg::t_wb_payload alu_payload,
   input  logic                   br_req,
   output logic                   br_grant,
   input  rob_pkg::t_rob_id       br_robid,
   input  logic                   br_mispred,
   input  instr_pkg::t_wb_payload br_payload,
   wb_bus_if.source               wb
);

   // High when the branch unit wins a tie
   logic br_first;

   assign alu_grant = alu_req && (!br_req || !br_first);
   assign br_grant  = br_req && (!alu_req || br_first);

   always_ff @(posedge clk) begin
      if (reset) begin
         br_first <= 1'b0;
      end else if (alu_grant) begin
         br_first <= 1'b1;
      end else if (br_grant) begin
         br_first <= 1'b0;
      end
   end

   // ALU results never mispredict
   assign wb.valid   = alu_grant || br_grant;
   assign wb.robid   = br_grant ? br_robid : alu_robid;
   assign wb.mispred = br_grant && br_mispred;
   assign wb.payload = br_grant ? br_payload : alu_payload;

   a_one_grant: assert property (@(posedge clk) disable iff (reset)
      !(alu_grant && br_grant));

endmodule

//--- hw/exec_branch.sv
`timescale 1ns/1ps
`include "rob_config.svh"

module exec_branch (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   issue_valid,
   output logic                   issue_ready,
   input  rob_pkg::t_rob_id       issue_robid,
   input  instr_pkg::t_br_cond    issue_cond,
   input  logic [`XLEN-1:0]       src_a,
   input  logic [`XLEN-1:0]       src_b,
   input  logic                   pred_taken,
   input  logic [`XLEN-1:0]       taken_target,
   input  logic [`XLEN-1:0]       fall_target,
   output logic                   req,
   input  logic                   grant,
   output rob_pkg::t_rob_id       res_robid,
   output logic                   res_mispred,
   output instr_pkg::t_wb_payload res_payload
);

   logic taken;
   logic issue_fire;

   always_comb begin
      case (issue_cond)
         instr_pkg::EQ:  taken = (src_a == src_b);
         instr_pkg::NE:  taken = (src_a != src_b);
         instr_pkg::LTU: taken = (src_a < src_b);
         default:        taken = 1'b0;
      endcase
   end

   assign issue_ready = !req || grant;
   assign issue_fire  = issue_valid && issue_ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         req <= 1'b0;
      end else if (issue_fire) begin
         req <= 1'b1;
      end else if (grant) begin
         req <= 1'b0;
      end
   end

   // Resolved next address goes out as the target view
   always_ff @(posedge clk) begin
      if (issue_fire) begin
         res_robid          <= issue_robid;
         res_mispred        <= (taken != pred_taken);
         res_payload.target <= taken ? taken_target : fall_target;
      end
   end

endmodule

//--- hw/exec_alu.sv
`timescale 1ns/1ps
`include "rob_config.svh"

module exec_alu (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   issue_valid,
   output logic                   issue_ready,
   input  rob_pkg::t_rob_id       issue_robid,
   input  instr_pkg::t_alu_op     issue_op,
   input  logic [`XLEN-1:0]       src_a,
   input  logic [`XLEN-1:0]       src_b,
   output logic                   req,
   input  logic                   grant,
   output rob_pkg::t_rob_id       res_robid,
   output instr_pkg::t_wb_payload res_payload
);

   logic [`XLEN-1:0] alu_out;
   logic             issue_fire;

   always_comb begin
      case (issue_op)
         instr_pkg::ADD: alu_out = src_a + src_b;
         instr_pkg::SUB: alu_out = src_a - src_b;
         instr_pkg::AND: alu_out = src_a & src_b;
         default:        alu_out = src_a ^ src_b;
      endcase
   end

   // Free once the held result leaves this cycle
   assign issue_ready = !req || grant;
   assign issue_fire  = issue_valid && issue_ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         req <= 1'b0;
      end else if (issue_fire) begin
         req <= 1'b1;
      end else if (grant) begin
         req <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (issue_fire) begin
         res_robid        <= issue_robid;
         res_payload.data <= alu_out;
      end
   end

   a_req_hold: assert property (@(posedge clk) disable iff (reset)
      req && !grant |=> req);

endmodule

//--- hw/rob_entry.sv
`timescale 1ns/1ps

module rob_entry (
   input  logic                     clk,
   input  logic                     reset,
   input  rob_pkg::t_rob_id         robid,
   input  rob_pkg::t_rob_ent_static alloc_s,
   input  logic                     alloc,
   wb_bus_if.sink                   wb,
   input  logic                     flush_now,
   input  logic                     retire,
   output rob_pkg::t_rob_ent        entry
);

   rob_pkg::t_rob_ent_state  state;
   rob_pkg::t_rob_ent_static stat;
   instr_pkg::t_wb_payload   payload;
   logic                     wb_hit;

   assign wb_hit = wb.valid && (wb.robid == robid);

   always_ff @(posedge clk) begin
      if (reset || flush_now) begin
         state <= rob_pkg::IDLE;
      end else begin
         case (state)
            rob_pkg::IDLE: begin
               if (alloc) state <= rob_pkg::PENDING;
            end
            rob_pkg::PENDING: begin
               if (wb_hit) state <= wb.mispred ? rob_pkg::FLUSH : rob_pkg::READY;
            end
            rob_pkg::READY: begin
               if (retire) state <= rob_pkg::IDLE;
            end
            // Parked until the queue flushes at the head
            default: begin
               state <= state;
            end
         endcase
      end
   end

   // Result capture
   always_ff @(posedge clk) begin
      if (wb_hit) begin
         payload <= wb.payload;
      end
   end

   // Kind and dest from the allocating stage
   always_ff @(posedge clk) begin
      if (alloc) begin
         stat <= alloc_s;
      end
   end

   assign entry.s       = stat;
   assign entry.state   = state;
   assign entry.payload = payload;

   a_alloc_idle: assert property (@(posedge clk) disable iff (reset)
      alloc |-> state == rob_pkg::IDLE);

   // Units must only write back ids that are still waiting
   a_wb_pending: assert property (@(posedge clk) disable iff (reset)
      wb_hit |-> state == rob_pkg::PENDING);

endmodule

//--- hw/wb_bus_if.sv
`timescale 1ns/1ps

interface wb_bus_if;

   logic                   valid;
   rob_pkg::t_rob_id       robid;
   logic                   mispred;
   instr_pkg::t_wb_payload payload;

   // Arbiter side
   modport source (
      output valid,
      output robid,
      output mispred,
      output payload
   );

   // Buffer side, no back-pressure
   modport sink (
      input valid,
      input robid,
      input mispred,
      input payload
   );

endinterface

//--- hw/rob_pkg.sv
`include "rob_config.svh"

package rob_pkg;

   typedef logic [`ROB_ID_W-1:0] t_rob_id;

   // Written once at allocation
   typedef struct packed {
      instr_pkg::t_instr_kind kind;
      logic [`REG_W-1:0]      dest;
   } t_rob_ent_static;

   // Slot life cycle
   typedef enum logic [1:0] {
      IDLE,
      PENDING,
      READY,
      FLUSH
   } t_rob_ent_state;

   // What the queue sees of one slot
   typedef struct packed {
      t_rob_ent_static        s;
      t_rob_ent_state         state;
      instr_pkg::t_wb_payload payload;
   } t_rob_ent;

endpackage

//--- hw/instr_pkg.sv
`include "rob_config.svh"

package instr_pkg;

   // Which unit executes the instruction
   typedef enum logic {
      KIND_ALU,
      KIND_BRANCH
   } t_instr_kind;

   typedef enum logic [1:0] {
      ADD,
      SUB,
      AND,
      XOR
   } t_alu_op;

   // Unsigned less-than only
   typedef enum logic [1:0] {
      EQ,
      NE,
      LTU
   } t_br_cond;

   // Writeback word, data for ALU results and target for branches
   typedef union packed {
      logic [`XLEN-1:0] data;
      logic [`XLEN-1:0] target;
   } t_wb_payload;

endpackage

//--- hw/rob_config.svh
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// Reorder buffer sizing

// Number of in-flight slots
`define ROB_DEPTH 8

// Slot index width, log2 of ROB_DEPTH
`define ROB_ID_W 3

// Datapath width
`define XLEN 32

// Destination register index width
`define REG_W 5

`endif
